// ==== logic/bp_macros.svh ====
// Branch predictor sizing constants: PC width, table index split, reset fetch PC
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// PC width
`define BP_XLEN 32

// Fetch PC held after reset
`define BP_PC_INIT 'h200

// Global history length
`define BP_GLOBAL_BITS 2

// PC bits in the table index, starting at bit 2
`define BP_LOCAL_BITS 4
`define BP_LOCAL_LSB 2

// Full table index, history above PC bits
`define BP_ADR_BITS (`BP_GLOBAL_BITS + `BP_LOCAL_BITS)

`endif

// ==== logic/bp_pkg.sv ====
// Branch predictor types: 2-bit counter encoding and resolved-branch update record
`default_nettype none
`include "bp_macros.svh"

package bp_pkg;

  // Counter chain 00 <-> 01 <-> 11 <-> 10
  // Upper bit is the taken prediction
  typedef enum logic [1:0] {
    BP_STRONG_NT = 2'b00,
    BP_WEAK_NT   = 2'b01,
    BP_WEAK_T    = 2'b11,
    BP_STRONG_T  = 2'b10
  } bp_counter_e;

  // Resolved branch from execute
  typedef struct packed {
    // Execute stage PC
    logic [`BP_XLEN-1:0] pc;
    // Counter value the branch was predicted with
    bp_counter_e         predict;
    // Actual outcome
    logic                taken;
    // Write strobe, one cycle per branch
    logic                strobe;
  } bp_update_t;

endpackage

`default_nettype wire

// ==== logic/bp_table_ram.sv ====
// Counter table RAM: one write port, one registered read port, old data on collision
`timescale 1ns/1ps
`default_nettype none

module bp_table_ram #(
  parameter int ABITS = 6,
  parameter int DBITS = 2
) (
  input  wire              clk_i,

  // Write side
  input  wire  [ABITS-1:0] waddr_i,
  input  wire              we_i,
  input  wire  [DBITS-1:0] din_i,

  // Read side
  input  wire  [ABITS-1:0] raddr_i,
  output logic [DBITS-1:0] dout_o
);

  localparam int DEPTH = 1 << ABITS;

  // Storage array, behaves like a macro
  // Contents undefined until written
  logic [DBITS-1:0] mem_q [DEPTH];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= din_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Registered read
  // Same-edge write lands after the sample, so old data comes out
  always_ff @(posedge clk_i) begin
    dout_o <= mem_q[raddr_i];
  end

endmodule

`default_nettype wire

// ==== logic/bp_history.sv ====
// Global branch history shift register and registered mispredict pulse
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

module bp_history (
  input  wire                              clk_i,
  input  wire                              rst_ni,

  // Resolved branch from execute
  input  wire bp_pkg::bp_update_t          upd_i,

  output logic [`BP_GLOBAL_BITS-1:0]       history_o,
  output logic                             mispredict_o
);

  logic [`BP_GLOBAL_BITS-1:0] history_q;
  logic                       mispredict_q;
  logic                       predicted_taken;
  logic                       wrong_dir;

  ////////////////////////////////////////////////////////////
  // History register
  ////////////////////////////////////////////////////////////

  // Newest outcome enters at bit 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history_q <= '0;
    end else if (upd_i.strobe) begin
      history_q <= {history_q[`BP_GLOBAL_BITS-2:0], upd_i.taken};
    end
  end

  ////////////////////////////////////////////////////////////
  // Mispredict detection
  ////////////////////////////////////////////////////////////

  // Direction the table gave for this branch
  assign predicted_taken = upd_i.predict[1];
  assign wrong_dir       = upd_i.strobe & (predicted_taken ^ upd_i.taken);

  // One cycle pulse per wrong direction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mispredict_q <= 1'b0;
    end else begin
      mispredict_q <= wrong_dir;
    end
  end

  assign history_o    = history_q;
  assign mispredict_o = mispredict_q;

endmodule

`default_nettype wire

// ==== logic/bp_predictor.sv ====
// Correlating predictor: fetch PC hold, table indexing, saturating counter update
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

module bp_predictor (
  input  wire                              clk_i,
  input  wire                              rst_ni,

  // Read side
  input  wire                              id_stall_i,
  input  wire  [`BP_XLEN-1:0]              if_pc_i,
  output bp_pkg::bp_counter_e              predict_o,

  // Write side
  input  wire  [`BP_GLOBAL_BITS-1:0]       history_i,
  input  wire bp_pkg::bp_update_t          upd_i
);

  logic [`BP_XLEN-1:0]     pc_hold_q;
  logic [`BP_XLEN-1:0]     rd_pc;
  logic [`BP_ADR_BITS-1:0] raddr;
  logic [`BP_ADR_BITS-1:0] waddr;
  bp_pkg::bp_counter_e     next_cnt;
  logic [1:0]              rd_cnt;

  ////////////////////////////////////////////////////////////
  // Fetch PC hold
  ////////////////////////////////////////////////////////////

  // Last PC seen while decode was moving
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_hold_q <= `BP_XLEN'(`BP_PC_INIT);
    end else if (!id_stall_i) begin
      pc_hold_q <= if_pc_i;
    end
  end

  // Stalled fetch keeps reading the held entry
  assign rd_pc = id_stall_i ? pc_hold_q : if_pc_i;

  ////////////////////////////////////////////////////////////
  // Table indices
  ////////////////////////////////////////////////////////////

  // History in the upper bits, PC bits below
  assign raddr = {history_i, rd_pc[`BP_LOCAL_LSB +: `BP_LOCAL_BITS]};
  // Write uses history before this branch shifts in
  assign waddr = {history_i, upd_i.pc[`BP_LOCAL_LSB +: `BP_LOCAL_BITS]};

  // One step along 00 <-> 01 <-> 11 <-> 10, saturating at the ends
  always_comb begin
    unique case (upd_i.predict)
      bp_pkg::BP_STRONG_NT: next_cnt = upd_i.taken ? bp_pkg::BP_WEAK_NT  : bp_pkg::BP_STRONG_NT;
      bp_pkg::BP_WEAK_NT:   next_cnt = upd_i.taken ? bp_pkg::BP_WEAK_T   : bp_pkg::BP_STRONG_NT;
      bp_pkg::BP_WEAK_T:    next_cnt = upd_i.taken ? bp_pkg::BP_STRONG_T : bp_pkg::BP_WEAK_NT;
      bp_pkg::BP_STRONG_T:  next_cnt = upd_i.taken ? bp_pkg::BP_STRONG_T : bp_pkg::BP_WEAK_T;
      default:              next_cnt = bp_pkg::BP_STRONG_NT;
    endcase
  end

  // Counter table
  bp_table_ram #(
    .ABITS ( `BP_ADR_BITS ),
    .DBITS ( 2            )
  ) u_table (
    .clk_i   ( clk_i        ),
    .waddr_i ( waddr        ),
    .we_i    ( upd_i.strobe ),
    .din_i   ( next_cnt     ),
    .raddr_i ( raddr        ),
    .dout_o  ( rd_cnt       )
  );

  assign predict_o = bp_pkg::bp_counter_e'(rd_cnt);

endmodule

`default_nettype wire

// ==== logic/bp_top.sv ====
// Branch prediction top: global history register feeding the correlating predictor
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

module bp_top (
  input  wire                              clk_i,
  input  wire                              rst_ni,

  // Fetch and decode
  input  wire                              id_stall_i,
  input  wire  [`BP_XLEN-1:0]              if_pc_i,

  // Branch unit
  input  wire bp_pkg::bp_update_t          upd_i,

  // Prediction and status
  output bp_pkg::bp_counter_e              predict_o,
  output logic                             mispredict_o,
  output logic [`BP_GLOBAL_BITS-1:0]       history_o
);

  // Current global history, shared by both blocks
  logic [`BP_GLOBAL_BITS-1:0] history;

  bp_history u_history (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .upd_i        ( upd_i        ),
    .history_o    ( history      ),
    .mispredict_o ( mispredict_o )
  );

  bp_predictor u_predictor (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .id_stall_i ( id_stall_i ),
    .if_pc_i    ( if_pc_i    ),
    .predict_o  ( predict_o  ),
    .history_i  ( history    ),
    .upd_i      ( upd_i      )
  );

  assign history_o = history;

endmodule

`default_nettype wire

// ==== test/bp_assert.sv ====
// Branch predictor assertions: write address, mispredict pulse and held fetch PC
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

module bp_assert (
  input wire                           clk_i,
  input wire                           rst_ni,
  input wire                           id_stall_i,
  input wire bp_pkg::bp_update_t       upd_i,
  input wire                           mispredict_i,
  input wire [`BP_XLEN-1:0]            pc_hold_i,
  input wire [`BP_ADR_BITS-1:0]        waddr_i
);

  logic strobe;

  assign strobe = upd_i.strobe;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Every strobed write lands on a known entry
  waddr_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      strobe |-> !$isunknown(waddr_i)
  ) else $error("Counter table write address unknown on an update strobe");

  // Back-to-back pulses need a branch behind each
  mispredict_pulse_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (mispredict_i && $past(mispredict_i)) |-> ($past(strobe) && $past(strobe, 2))
  ) else $error("Mispredict high two cycles in a row without two updates");

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Decode stall freezes the held fetch PC
  pc_hold_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      id_stall_i |=> $stable(pc_hold_i)
  ) else $error("Held fetch PC changed while decode was stalled");

endmodule

`default_nettype wire

// ==== test/bp_tb.sv ====
// Branch predictor testbench with pattern stimulus, per-cycle checks, watchdog and summary
`timescale 1ns/1ps
`default_nettype none
`include "bp_macros.svh"

module bp_tb;

  localparam int CLK_HALF     = 4;
  localparam int CLK_PERIOD   = 2 * CLK_HALF;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DLY    = 1;
  localparam int SLACK_CYCLES = 20;

  // One clock cycle of stimulus and its expected response
  typedef struct packed {
    logic                       stall;
    logic [`BP_XLEN-1:0]        pc;
    bp_pkg::bp_update_t         upd;
    logic [1:0]                 exp_pred;
    logic                       chk;
    logic                       exp_mis;
  } pattern_t;

  // DUT signals
  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        id_stall;
  logic [`BP_XLEN-1:0]         if_pc;
  bp_pkg::bp_update_t          upd;
  bp_pkg::bp_counter_e         predict;
  logic                        mispredict;
  logic [`BP_GLOBAL_BITS-1:0]  history;

  // Bookkeeping
  pattern_t                    patterns[$];
  bit                          patterns_loaded = 1'b0;
  int                          errors = 0;
  int                          checks = 0;
  // Update outcomes seen so far, newest first
  bit                          outcomes[$];

  always #(CLK_HALF) clk = ~clk;

  bp_top bp_top_inst (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .id_stall_i   ( id_stall   ),
    .if_pc_i      ( if_pc      ),
    .upd_i        ( upd        ),
    .predict_o    ( predict    ),
    .mispredict_o ( mispredict ),
    .history_o    ( history    )
  );

  // Predictor rules watched from the top level
  bind bp_top bp_assert assert_inst (
    .clk_i        ( clk_i                 ),
    .rst_ni       ( rst_ni                ),
    .id_stall_i   ( id_stall_i            ),
    .upd_i        ( upd_i                 ),
    .mispredict_i ( mispredict_o          ),
    .pc_hold_i    ( u_predictor.pc_hold_q ),
    .waddr_i      ( u_predictor.waddr     )
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s at %0t ns: got %h, expected %h", name, $time, got, exp);
    end
  endtask

  // Pattern file in hex columns with '#' header lines
  task automatic load_patterns();
    int          fd;
    int          code;
    int          n;
    string       line_s;
    logic [31:0] f_stall, f_pc, f_upc, f_pred, f_taken, f_strobe, f_exp, f_chk, f_mis;
    pattern_t    row;
    fd = $fopen("test/bp_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file test/bp_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line_s, fd);
        if (code > 0) begin
          n = $sscanf(line_s, "%h %h %h %h %h %h %h %h %h", f_stall, f_pc, f_upc,
                      f_pred, f_taken, f_strobe, f_exp, f_chk, f_mis);
          if (n == 9) begin
            row.stall       = f_stall[0];
            row.pc          = f_pc[`BP_XLEN-1:0];
            row.upd.pc      = f_upc[`BP_XLEN-1:0];
            row.upd.predict = bp_pkg::bp_counter_e'(f_pred[1:0]);
            row.upd.taken   = f_taken[0];
            row.upd.strobe  = f_strobe[0];
            row.exp_pred    = f_exp[1:0];
            row.chk         = f_chk[0];
            row.exp_mis     = f_mis[0];
            patterns.push_back(row);
          end
        end
      end
      $fclose(fd);
    end
    patterns_loaded = 1'b1;
  endtask

  task automatic apply_row(input pattern_t row);
    id_stall = row.stall;
    if_pc    = row.pc;
    upd      = row.upd;
  endtask

  // Response to the row sampled at the last edge
  task automatic check_row(input pattern_t row);
    int                         k;
    logic [`BP_GLOBAL_BITS-1:0] exp_hist;
    if (row.upd.strobe) begin
      outcomes.push_front(row.upd.taken);
    end
    // History bit k holds the k-th newest outcome or zero
    for (k = 0; k < `BP_GLOBAL_BITS; k++) begin
      exp_hist[k] = (k < outcomes.size()) ? outcomes[k] : 1'b0;
    end
    if (row.chk) begin
      check_value("predict_o", 32'(predict), 32'(row.exp_pred));
    end
    check_value("mispredict_o", 32'(mispredict), 32'(row.exp_mis));
    check_value("history_o", 32'(history), 32'(exp_hist));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int i;
    rst_n    = 1'b0;
    id_stall = 1'b0;
    if_pc    = `BP_XLEN'(`BP_PC_INIT);
    upd      = '0;
    load_patterns();
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    // Clean state straight out of reset
    check_value("history_o", 32'(history), 32'(0));
    check_value("mispredict_o", 32'(mispredict), 32'(0));
    for (i = 0; i < patterns.size(); i++) begin
      apply_row(patterns[i]);
      @(posedge clk);
      #(DRIVE_DLY);
      check_row(patterns[i]);
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Limit is pattern length plus slack
  initial begin : watchdog
    int limit_ns;
    wait (patterns_loaded);
    limit_ns = (patterns.size() + SLACK_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    $display("Watchdog expired after %0d ns before the pattern run ended", limit_ns);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/bp_patterns.txt ====
# stall if_pc upd_pc upd_pred upd_taken upd_strobe exp_predict check_mask exp_mispredict
# all columns hex, one line per clock, expected values belong to the same line
0 00000100 00000000 0 0 0 0 0 0
0 00000100 00000100 0 1 1 0 0 1
0 00000100 00000100 1 1 1 0 0 1
0 00000104 00000100 0 1 1 0 0 1
0 00000100 00000000 0 0 0 1 1 0
0 00000100 00000100 1 1 1 1 1 1
0 00000100 00000100 3 1 1 3 1 0
0 00000100 00000100 2 1 1 2 1 0
0 00000100 00000000 0 0 0 2 1 0
0 00000100 00000100 2 0 1 2 1 1
0 00000100 00000100 3 0 1 0 0 1
0 00000100 00000100 1 0 1 1 1 0
0 00000100 00000100 0 0 1 0 1 0
0 00000100 00000000 0 0 0 0 1 0
0 00000100 0000010c 0 1 1 0 1 1
0 00000100 0000010c 0 0 1 3 1 0
0 00000100 0000010c 2 1 1 1 1 0
0 00000100 0000010c 0 1 1 3 1 1
0 00000100 00000000 0 0 0 3 1 0
1 00000104 00000100 3 1 1 3 1 0
1 00000108 00000000 0 0 0 2 1 0
1 00000108 00000100 2 0 1 2 1 1
1 0000010c 00000000 0 0 0 1 1 0

// ==== vlog.f ====
+incdir+logic
logic/bp_pkg.sv
logic/bp_table_ram.sv
logic/bp_history.sv
logic/bp_predictor.sv
logic/bp_top.sv
test/bp_assert.sv
test/bp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator, run it and scan the log

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bp_tb -f vlog.f --Mdir obj_dir -o bp_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/bp_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0
